//--- hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic                  Clock,
    input  logic                  rstN,
    input  logic                  run,
    input  cpuIsaPkg::instr_t     instr,
    output cpuCtrlPkg::ctrlWord_t ctrl,
    output logic                  instrDone
);

    cpuCtrlPkg::step_t step;
    cpuCtrlPkg::step_t stepNext;
    logic              isLdi;

    // Only ld and st run on to T7
    assign isLdi = (instr.opcode != cpuIsaPkg::opLd) && (instr.opcode != cpuIsaPkg::opSt);

    assign instrDone = (step == cpuCtrlPkg::stepT7) || (step == cpuCtrlPkg::stepT5 && isLdi);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            step <= cpuCtrlPkg::stepT0;
        end else begin
            step <= stepNext;
        end
    end

    always_comb begin
        stepNext = step;
        case (step)
            cpuCtrlPkg::stepT0: stepNext = run ? cpuCtrlPkg::stepT1 : cpuCtrlPkg::stepT0;
            cpuCtrlPkg::stepT1: stepNext = cpuCtrlPkg::stepT2;
            cpuCtrlPkg::stepT2: stepNext = cpuCtrlPkg::stepT3;
            cpuCtrlPkg::stepT3: stepNext = cpuCtrlPkg::stepT4;
            cpuCtrlPkg::stepT4: stepNext = cpuCtrlPkg::stepT5;
            cpuCtrlPkg::stepT5: stepNext = isLdi ? cpuCtrlPkg::stepT0 : cpuCtrlPkg::stepT6;
            cpuCtrlPkg::stepT6: stepNext = cpuCtrlPkg::stepT7;
            default:            stepNext = cpuCtrlPkg::stepT0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.busSrc = cpuCtrlPkg::busNone;
        case (step)
            cpuCtrlPkg::stepT0: begin
                if (run) begin // Stalled here until run
                    ctrl.busSrc  = cpuCtrlPkg::busPc;
                    ctrl.marIn   = 1'b1;
                    ctrl.incPc   = 1'b1;
                    ctrl.zIn     = 1'b1;
                    ctrl.memRead = 1'b1;
                end
            end
            cpuCtrlPkg::stepT1: begin
                ctrl.busSrc     = cpuCtrlPkg::busZ;
                ctrl.pcIn       = 1'b1;
                ctrl.mdrIn      = 1'b1;
                ctrl.mdrFromMem = 1'b1;
            end
            cpuCtrlPkg::stepT2: begin
                ctrl.busSrc = cpuCtrlPkg::busMdr;
                ctrl.irIn   = 1'b1;
            end
            cpuCtrlPkg::stepT3: begin
                ctrl.busSrc = cpuCtrlPkg::busReg; // Base into Y
                ctrl.regOut = 1'b1;
                ctrl.selRb  = 1'b1;
                ctrl.yIn    = 1'b1;
            end
            cpuCtrlPkg::stepT4: begin
                ctrl.busSrc = cpuCtrlPkg::busConst;
                ctrl.zIn    = 1'b1;
            end
            cpuCtrlPkg::stepT5: begin
                ctrl.busSrc = cpuCtrlPkg::busZ;
                if (isLdi) begin
                    ctrl.regIn = 1'b1;
                    ctrl.selRa = 1'b1;
                end else begin
                    ctrl.marIn   = 1'b1;
                    ctrl.memRead = (instr.opcode == cpuIsaPkg::opLd);
                end
            end
            cpuCtrlPkg::stepT6: begin
                ctrl.mdrIn = 1'b1;
                if (instr.opcode == cpuIsaPkg::opLd) begin
                    ctrl.mdrFromMem = 1'b1;
                end else begin
                    ctrl.busSrc = cpuCtrlPkg::busReg; // Store data from R[ra]
                    ctrl.regOut = 1'b1;
                    ctrl.selRa  = 1'b1;
                end
            end
            default: begin
                if (instr.opcode == cpuIsaPkg::opLd) begin
                    ctrl.busSrc = cpuCtrlPkg::busMdr;
                    ctrl.regIn  = 1'b1;
                    ctrl.selRa  = 1'b1;
                end else begin
                    ctrl.memWrite = 1'b1;
                end
            end
        endcase
    end

endmodule

//--- hw/cpuCtrlPkg.sv
package cpuCtrlPkg;

    typedef enum logic [2:0] {
        stepT0, stepT1, stepT2, stepT3,
        stepT4, stepT5, stepT6, stepT7
    } step_t;

    // Which block drives the shared bus this cycle
    typedef enum logic [2:0] {
        busNone,
        busPc,
        busMdr,
        busZ,
        busReg,
        busConst
    } busSrc_t;

    typedef struct packed {
        busSrc_t busSrc;
        logic    pcIn;
        logic    incPc;      // Adder forms bus + 1 instead of Y + bus
        logic    marIn;
        logic    mdrIn;
        logic    mdrFromMem; // MDR loads memory instead of the bus
        logic    irIn;
        logic    yIn;
        logic    zIn;
        logic    regIn;
        logic    regOut;
        logic    selRa;
        logic    selRb;      // Base read that gives zero for index 0
        logic    memRead;
        logic    memWrite;
    } ctrlWord_t;

    typedef struct packed {
        logic              en;
        cpuIsaPkg::addr_t  addr;
        cpuIsaPkg::word_t  data;
    } memLoad_t;

    typedef struct packed {
        logic               en;
        cpuIsaPkg::regIdx_t idx;
        cpuIsaPkg::word_t   data;
    } regWrite_t;

    typedef struct packed {
        logic             en;
        cpuIsaPkg::addr_t addr;
        cpuIsaPkg::word_t data;
    } memWrite_t;

endpackage

//--- hw/cpuIsaPkg.sv
package cpuIsaPkg;

    localparam int dataWidth   = 32;
    localparam int addrWidth   = 9;
    localparam int regIdxWidth = 4;
    localparam int constWidth  = 19;
    localparam int opcodeWidth = 5;
    localparam int memDepth    = 512;
    localparam int numRegs     = 16;

    typedef logic [dataWidth-1:0]   word_t;
    typedef logic [addrWidth-1:0]   addr_t;
    typedef logic [regIdxWidth-1:0] regIdx_t;
    typedef logic [constWidth-1:0]  constField_t;

    // Anything other than ld or st runs as ldi
    typedef enum logic [opcodeWidth-1:0] {
        opLd  = 5'd0,
        opLdi = 5'd1,
        opSt  = 5'd2
    } opcode_t;

    // Bit 31 down to bit 0
    typedef struct packed {
        opcode_t     opcode;
        regIdx_t     ra;
        regIdx_t     rb;
        constField_t constant;
    } instr_t;

endpackage

//--- hw/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic                  Clock,
    input  logic                  rstN,
    input  logic                  run,
    input  cpuCtrlPkg::memLoad_t  load,
    output cpuCtrlPkg::regWrite_t regWrite,
    output cpuCtrlPkg::memWrite_t memWrite,
    output logic                  instrDone
);

    cpuCtrlPkg::ctrlWord_t ctrl;
    cpuIsaPkg::instr_t     instr;
    cpuIsaPkg::regIdx_t    regIdx;
    logic                  regWe;
    cpuIsaPkg::word_t      regWdata;
    cpuIsaPkg::word_t      regRdata;
    cpuIsaPkg::addr_t      memAddr;
    cpuIsaPkg::word_t      memWdata;
    cpuIsaPkg::word_t      memRdata;

    controlUnit controlUnit_i (
        .Clock     (Clock),
        .rstN      (rstN),
        .run       (run),
        .instr     (instr),
        .ctrl      (ctrl),
        .instrDone (instrDone)
    );

    datapath datapath_i (
        .Clock    (Clock),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .memRdata (memRdata),
        .regRdata (regRdata),
        .instr    (instr),
        .regIdx   (regIdx),
        .regWe    (regWe),
        .regWdata (regWdata),
        .memAddr  (memAddr),
        .memWdata (memWdata)
    );

    regFile regFile_i (
        .Clock    (Clock),
        .rstN     (rstN),
        .idx      (regIdx),
        .we       (regWe),
        .wdata    (regWdata),
        .baseMode (ctrl.selRb),
        .rdata    (regRdata)
    );

    mainMemory mainMemory_i (
        .Clock (Clock),
        .ctrl  (ctrl),
        .addr  (memAddr),
        .wdata (memWdata),
        .load  (load),
        .run   (run),
        .rdata (memRdata)
    );

    // Observation copies of the write strobes
    assign regWrite = '{en: regWe, idx: regIdx, data: regWdata};
    assign memWrite = '{en: ctrl.memWrite, addr: memAddr, data: memWdata};

endmodule

//--- hw/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                  Clock,
    input  logic                  rstN,
    input  cpuCtrlPkg::ctrlWord_t ctrl,
    input  cpuIsaPkg::word_t      memRdata,
    input  cpuIsaPkg::word_t      regRdata,
    output cpuIsaPkg::instr_t     instr,
    output cpuIsaPkg::regIdx_t    regIdx,
    output logic                  regWe,
    output cpuIsaPkg::word_t      regWdata,
    output cpuIsaPkg::addr_t      memAddr,
    output cpuIsaPkg::word_t      memWdata
);

    cpuIsaPkg::word_t  pc;
    cpuIsaPkg::instr_t ir;
    cpuIsaPkg::addr_t  mar;
    cpuIsaPkg::word_t  mdr;
    cpuIsaPkg::word_t  y;
    cpuIsaPkg::word_t  z;

    cpuIsaPkg::word_t  bus;
    cpuIsaPkg::word_t  constExt;
    cpuIsaPkg::word_t  opA;
    cpuIsaPkg::word_t  opB;
    cpuIsaPkg::word_t  sum;

    assign constExt = {{(cpuIsaPkg::dataWidth - cpuIsaPkg::constWidth)
                           {ir.constant[cpuIsaPkg::constWidth-1]}},
                       ir.constant};

    always_comb begin
        case (ctrl.busSrc)
            cpuCtrlPkg::busPc:    bus = pc;
            cpuCtrlPkg::busMdr:   bus = mdr;
            cpuCtrlPkg::busZ:     bus = z;
            cpuCtrlPkg::busReg:   bus = ctrl.regOut ? regRdata : '0;
            cpuCtrlPkg::busConst: bus = constExt;
            default:              bus = '0;
        endcase
    end

    // One adder for both PC+1 and Y+C
    assign opA = ctrl.incPc ? bus : y;
    assign opB = ctrl.incPc ? cpuIsaPkg::word_t'(1) : bus;
    assign sum = opA + opB;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pc <= '0;
        end else if (ctrl.pcIn) begin
            pc <= bus;
        end
    end

    always_ff @(posedge Clock) begin
        if (ctrl.irIn) begin
            ir <= bus;
        end
        if (ctrl.marIn) begin
            mar <= bus[cpuIsaPkg::addrWidth-1:0]; // Low 9 bits address memory
        end
        if (ctrl.mdrIn) begin
            mdr <= ctrl.mdrFromMem ? memRdata : bus;
        end
        if (ctrl.yIn) begin
            y <= bus;
        end
        if (ctrl.zIn) begin
            z <= sum;
        end
    end

    assign instr    = ir;
    assign regIdx   = ctrl.selRa ? ir.ra : ir.rb;
    assign regWe    = ctrl.regIn;
    assign regWdata = bus;

    // MAR load passes straight through so a read can start in the same cycle
    assign memAddr  = ctrl.marIn ? bus[cpuIsaPkg::addrWidth-1:0] : mar;
    assign memWdata = mdr;

endmodule

//--- hw/mainMemory.sv
`timescale 1ns/1ps

module mainMemory (
    input  logic                  Clock,
    input  cpuCtrlPkg::ctrlWord_t ctrl,
    input  cpuIsaPkg::addr_t      addr,
    input  cpuIsaPkg::word_t      wdata,
    input  cpuCtrlPkg::memLoad_t  load,
    input  logic                  run,
    output cpuIsaPkg::word_t      rdata
);

    cpuIsaPkg::word_t mem [cpuIsaPkg::memDepth];

    always_ff @(posedge Clock) begin
        if (!run && load.en) begin
            mem[load.addr] <= load.data; // Program and data preload
        end else if (ctrl.memWrite) begin
            mem[addr] <= wdata;
        end
    end

    // Word shows up the cycle after memRead
    always_ff @(posedge Clock) begin
        if (ctrl.memRead) begin
            rdata <= mem[addr];
        end
    end

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic               Clock,
    input  logic               rstN,
    input  cpuIsaPkg::regIdx_t idx,
    input  logic               we,
    input  cpuIsaPkg::word_t   wdata,
    input  logic               baseMode,
    output cpuIsaPkg::word_t   rdata
);

    cpuIsaPkg::word_t regs [cpuIsaPkg::numRegs];

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < cpuIsaPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[idx] <= wdata;
        end
    end

    // R0 as a base means no base at all
    assign rdata = (baseMode && idx == '0) ? '0 : regs[idx];

endmodule

//--- run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line in the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module cpuTop_tb -o cpuTop_sim \
    && ./obj_dir/cpuTop_sim | tee sim.log \
    && grep -q "TEST RESULT: PASS" sim.log \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run failed"; exit 1; }

//--- tests/cpuTop_chk.sv
`timescale 1ns/1ps

module cpuTop_chk (
    input logic                  Clock,
    input logic                  rstN,
    input logic                  run,
    input cpuCtrlPkg::step_t     step,
    input cpuCtrlPkg::ctrlWord_t ctrl,
    input logic                  instrDone
);

    memPortExclusive: assert property (@(posedge Clock) disable iff (!rstN)
        !(ctrl.memRead && ctrl.memWrite))
        else $error("memRead and memWrite are high in the same cycle");

    // Done comes with the write of the last step
    doneInLastStep: assert property (@(posedge Clock) disable iff (!rstN)
        instrDone |-> ((step == cpuCtrlPkg::stepT5 || step == cpuCtrlPkg::stepT7)
                       && (ctrl.regIn || ctrl.memWrite)))
        else $error("instrDone is high outside the write step of T5 or T7");

    idleWhileStopped: assert property (@(posedge Clock) disable iff (!rstN)
        (step == cpuCtrlPkg::stepT0 && !run) |-> (ctrl == '0))
        else $error("Control strobes are active in T0 while run is low");

    regMemWriteExclusive: assert property (@(posedge Clock) disable iff (!rstN)
        !(ctrl.regIn && ctrl.memWrite))
        else $error("regIn and memWrite are high in the same cycle");

endmodule

bind controlUnit cpuTop_chk cpuTop_chk_i (
    .Clock     (Clock),
    .rstN      (rstN),
    .run       (run),
    .step      (step),
    .ctrl      (ctrl),
    .instrDone (instrDone)
);

//--- tests/cpuTop_tb.sv
`timescale 1ns/1ps

module cpuTop_tb;

    localparam int progLen   = 40; // Program at the bottom and data in the upper half
    localparam int waitLimit = 20;

    logic                  Clock;
    logic                  rstN;
    logic                  run;
    cpuCtrlPkg::memLoad_t  load;
    cpuCtrlPkg::regWrite_t regWrite;
    cpuCtrlPkg::memWrite_t memWrite;
    logic                  instrDone;

    logic [31:0]        rngState;
    cpuIsaPkg::word_t   modelRegs [cpuIsaPkg::numRegs];
    cpuIsaPkg::word_t   modelMem [cpuIsaPkg::memDepth];
    cpuIsaPkg::opcode_t expOp [progLen];
    cpuIsaPkg::regIdx_t expIdx [progLen];
    cpuIsaPkg::addr_t   expAddr [progLen];
    cpuIsaPkg::word_t   expData [progLen];
    string              testName [progLen];
    int                 errCount;
    int                 timeoutCount;

    cpuTop cpuTop_i (
        .Clock     (Clock),
        .rstN      (rstN),
        .run       (run),
        .load      (load),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .instrDone (instrDone)
    );

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    function automatic logic [31:0] nextRand(); // xorshift32
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic reportMismatch(input string name, input string field,
                                  input cpuIsaPkg::word_t expVal, input cpuIsaPkg::word_t actVal);
        errCount++;
        $display("[ERROR] %s %s: expected %h, actual %h", name, field, expVal, actVal);
    endtask

    // Fills one program slot and steps the register and memory model
    task automatic appendInstr(input int i, input cpuIsaPkg::opcode_t op,
                               input cpuIsaPkg::regIdx_t ra, input cpuIsaPkg::regIdx_t rb,
                               inout cpuIsaPkg::constField_t c);
        cpuIsaPkg::word_t  base;
        cpuIsaPkg::word_t  ea;
        cpuIsaPkg::instr_t ins;
        base = (rb == 4'd0) ? '0 : modelRegs[rb];
        ea   = base + {{13{c[18]}}, c};
        if (op != cpuIsaPkg::opLdi && !ea[8]) begin
            c[8] = ~c[8]; // Moves ea into the upper half
            ea   = base + {{13{c[18]}}, c};
        end
        ins         = '{opcode: op, ra: ra, rb: rb, constant: c};
        modelMem[i] = ins;
        expOp[i]    = op;
        expIdx[i]   = ra;
        expAddr[i]  = ea[8:0];
        if (op == cpuIsaPkg::opLdi) begin
            expData[i]  = ea;
            testName[i] = "ldi reg base";
            if (rb == 4'd0) begin
                testName[i] = "ldi zero base";
            end
        end else if (op == cpuIsaPkg::opLd) begin
            expData[i]  = modelMem[ea[8:0]];
            testName[i] = "ld";
        end else begin
            expData[i]        = modelRegs[ra];
            modelMem[ea[8:0]] = modelRegs[ra];
            testName[i]       = "st";
        end
        if (op != cpuIsaPkg::opSt) begin
            modelRegs[ra] = expData[i];
        end
    endtask

    task automatic buildProgram();
        int                     i;
        logic [31:0]            r;
        cpuIsaPkg::opcode_t     op;
        cpuIsaPkg::regIdx_t     rb;
        cpuIsaPkg::constField_t c;
        for (int a = 0; a < cpuIsaPkg::numRegs; a++) begin
            modelRegs[a] = '0;
        end
        for (int a = 0; a < cpuIsaPkg::memDepth; a++) begin
            modelMem[a] = nextRand();
        end
        i = 0;
        while (i < progLen) begin
            r  = nextRand();
            c  = cpuIsaPkg::constField_t'(nextRand());
            rb = (r[9:8] == 2'b00) ? 4'd0 : r[13:10]; // Bias toward the zero base
            if (r[31:20] % 12'd3 == 12'd0) begin
                op = cpuIsaPkg::opLd;
            end else if (r[31:20] % 12'd3 == 12'd1 || i == progLen - 1) begin
                op = cpuIsaPkg::opLdi;
            end else begin
                op = cpuIsaPkg::opSt;
            end
            appendInstr(i, op, r[7:4], rb, c);
            i++;
            if (op == cpuIsaPkg::opSt) begin
                appendInstr(i, cpuIsaPkg::opLd, r[17:14], rb, c); // Same ea as the store
                testName[i] = "ld after st";
                i++;
            end
        end
    endtask

    task automatic checkWrite(input int idx);
        if (expOp[idx] == cpuIsaPkg::opSt) begin
            assert (memWrite.en && !regWrite.en) else begin
                errCount++;
                $display("%s: no lone memory write came in the last step", testName[idx]);
            end
            assert (memWrite.addr == expAddr[idx]) else
                reportMismatch(testName[idx], "addr", cpuIsaPkg::word_t'(expAddr[idx]),
                               cpuIsaPkg::word_t'(memWrite.addr));
            assert (memWrite.data == expData[idx]) else
                reportMismatch(testName[idx], "data", expData[idx], memWrite.data);
        end else begin
            assert (regWrite.en && !memWrite.en) else begin
                errCount++;
                $display("%s: no lone register write came in the last step", testName[idx]);
            end
            assert (regWrite.idx == expIdx[idx]) else
                reportMismatch(testName[idx], "idx", cpuIsaPkg::word_t'(expIdx[idx]),
                               cpuIsaPkg::word_t'(regWrite.idx));
            assert (regWrite.data == expData[idx]) else
                reportMismatch(testName[idx], "data", expData[idx], regWrite.data);
        end
    endtask

    initial begin
        int idx;
        int gap;
        int expGap;
        rstN         = 1'b0;
        run          = 1'b0;
        load         = '0;
        errCount     = 0;
        timeoutCount = 0;
        rngState     = 32'h90f1ac67;
        buildProgram();
        repeat (5) @(negedge Clock);
        rstN = 1'b1;
        // Every word is preloaded so each ld sees a known value
        for (int a = 0; a <= cpuIsaPkg::memDepth; a++) begin
            @(negedge Clock);
            assert (!regWrite.en && !memWrite.en && !instrDone) else begin
                errCount++;
                $display("A write or instrDone showed up while run was low");
            end
            load.en   = (a < cpuIsaPkg::memDepth);
            load.addr = cpuIsaPkg::addr_t'(a);
            load.data = modelMem[a % cpuIsaPkg::memDepth];
        end
        run = 1'b1;
        idx = 0;
        gap = 0;
        while (idx < progLen && gap < waitLimit) begin
            @(negedge Clock);
            gap++;
            if (instrDone) begin
                checkWrite(idx);
                expGap = (expOp[idx] == cpuIsaPkg::opLdi) ? 6 : 8;
                if (idx > 0) begin
                    assert (gap == expGap) else
                        reportMismatch(testName[idx], "instrDone gap",
                                       cpuIsaPkg::word_t'(expGap), cpuIsaPkg::word_t'(gap));
                end
                idx++;
                gap = 0;
            end else begin
                assert (!regWrite.en && !memWrite.en) else begin
                    errCount++;
                    $display("%s: a write came in a cycle without instrDone", testName[idx]);
                end
            end
        end
        if (idx < progLen) begin
            timeoutCount++;
            $display("Timeout: no instrDone arrived for instruction %0d", idx);
        end
        $display("Errors: %0d mismatches, %0d timeouts", errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/cpuIsaPkg.sv
hw/cpuCtrlPkg.sv
hw/regFile.sv
hw/mainMemory.sv
hw/datapath.sv
hw/controlUnit.sv
hw/cpuTop.sv
tests/cpuTop_chk.sv
tests/cpuTop_tb.sv
